// File: Bender.yml
package:
  name: cam_config

sources:
  - source/cam_pkg.sv
  - source/sccb_byte_writer.sv
  - source/cam_delay_timer.sv
  - source/cam_init_fsm.sv
  - source/cam_config_top.sv
  - target: test
    files:
      - testbench/tb_sccb_slave.sv
      - testbench/tb_cam_config.sv

// File: cam_config.f
source/cam_pkg.sv
source/sccb_byte_writer.sv
source/cam_delay_timer.sv
source/cam_init_fsm.sv
source/cam_config_top.sv
testbench/tb_sccb_slave.sv
testbench/tb_cam_config.sv

// File: source/cam_config_top.sv
module cam_config_top #(
    parameter int scl_quarter     = cam_pkg::SCL_QUARTER,
    parameter int short_delay_bit = cam_pkg::SHORT_DELAY_BIT,
    parameter int long_delay_bit  = cam_pkg::LONG_DELAY_BIT
) (
    input  logic             clk,
    input  logic             rst_n,
    output logic             scl,
    inout  wire              sda,
    output logic             cmos_pwdn,
    output logic             cmos_rst_n,
    output cam_pkg::status_t status,
    output logic             config_done
);
    logic           delay_start;
    logic           long_delay;
    logic           delay_expired;
    logic           frame_start;
    logic           byte_load;
    logic           frame_stop;
    cam_pkg::byte_t tx_byte;
    logic           byte_done;
    logic           ack_ok;
    logic           stop_done;

    assign cmos_pwdn  = 1'b0;  // Camera always powered
    assign cmos_rst_n = 1'b1;  // Hardware reset never asserted

    cam_init_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .delay_expired (delay_expired),
        .byte_done     (byte_done),
        .ack_ok        (ack_ok),
        .stop_done     (stop_done),
        .delay_start   (delay_start),
        .long_delay    (long_delay),
        .frame_start   (frame_start),
        .byte_load     (byte_load),
        .frame_stop    (frame_stop),
        .tx_byte       (tx_byte),
        .status        (status),
        .config_done   (config_done)
    );

    cam_delay_timer #(
        .short_delay_bit (short_delay_bit),
        .long_delay_bit  (long_delay_bit)
    ) u_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .delay_start   (delay_start),
        .long_delay    (long_delay),
        .delay_expired (delay_expired)
    );

    sccb_byte_writer #(
        .scl_quarter (scl_quarter)
    ) u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .byte_load   (byte_load),
        .frame_stop  (frame_stop),
        .tx_byte     (tx_byte),
        .scl         (scl),
        .sda         (sda),
        .byte_done   (byte_done),
        .ack_ok      (ack_ok),
        .stop_done   (stop_done)
    );

endmodule

// File: source/cam_delay_timer.sv
module cam_delay_timer #(
    parameter int short_delay_bit = cam_pkg::SHORT_DELAY_BIT,
    parameter int long_delay_bit  = cam_pkg::LONG_DELAY_BIT
) (
    input  logic clk,
    input  logic rst_n,
    input  logic delay_start,   // Arms the counter
    input  logic long_delay,    // Exponent select, taken with delay_start
    output logic delay_expired  // One cycle, 2^N after delay_start
);
    logic [long_delay_bit:0] count;
    logic                    armed;
    logic                    sel_long;

    // Selected bit set means 2^N cycles elapsed
    assign delay_expired = armed && (sel_long ? count[long_delay_bit] : count[short_delay_bit]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b0;
            sel_long <= 1'b0;
            count    <= '0;
        end else if (delay_start) begin
            armed    <= 1'b1;
            sel_long <= long_delay;
            count    <= 1;             // Start cycle counts as the first
        end else if (delay_expired) begin
            armed <= 1'b0;             // Fire once, then idle
            count <= '0;
        end else if (armed) begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: source/cam_init_fsm.sv
module cam_init_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             delay_expired,
    input  logic             byte_done,
    input  logic             ack_ok,
    input  logic             stop_done,
    output logic             delay_start,
    output logic             long_delay,
    output logic             frame_start,
    output logic             byte_load,
    output logic             frame_stop,
    output cam_pkg::byte_t   tx_byte,
    output cam_pkg::status_t status,
    output logic             config_done
);
    cam_pkg::init_state_t state;
    cam_pkg::entry_idx_t  idx;           // Current table entry
    logic                 boot_pending;  // Power-up delay not yet started
    logic                 frame_ok;      // No NACK in this frame
    logic                 last_entry;

    assign last_entry = (idx == cam_pkg::entry_idx_t'(cam_pkg::NUM_ENTRIES - 1));

    // Byte for the writer, by phase of the frame
    always_comb begin
        case (state)
            cam_pkg::send_addr: tx_byte = cam_pkg::INIT_TABLE[idx][15:8];
            cam_pkg::send_data: tx_byte = cam_pkg::INIT_TABLE[idx][7:0];
            default:            tx_byte = cam_pkg::SCCB_WRITE_ID;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= cam_pkg::power_up_wait;
            idx          <= '0;
            boot_pending <= 1'b1;
            frame_ok     <= 1'b0;
            delay_start  <= 1'b0;
            long_delay   <= 1'b0;
            frame_start  <= 1'b0;
            byte_load    <= 1'b0;
            frame_stop   <= 1'b0;
            status       <= cam_pkg::STATUS_RESET;
            config_done  <= 1'b0;
        end else begin
            delay_start <= 1'b0;
            frame_start <= 1'b0;
            byte_load   <= 1'b0;
            frame_stop  <= 1'b0;
            case (state)
                cam_pkg::power_up_wait: begin
                    if (boot_pending) begin
                        delay_start  <= 1'b1;
                        long_delay   <= 1'b1;  // Camera power-up time
                        boot_pending <= 1'b0;
                    end else if (delay_expired) begin
                        state       <= cam_pkg::send_id;
                        frame_start <= 1'b1;
                        frame_ok    <= 1'b1;
                        status      <= cam_pkg::STATUS_ID;
                    end
                end
                cam_pkg::send_id, cam_pkg::send_addr: begin
                    if (byte_done && ack_ok) begin
                        byte_load <= 1'b1;
                        if (state == cam_pkg::send_id) begin
                            state  <= cam_pkg::send_addr;
                            status <= cam_pkg::STATUS_ADDR;
                        end else begin
                            state  <= cam_pkg::send_data;
                            status <= cam_pkg::STATUS_DATA;
                        end
                    end else if (byte_done) begin
                        frame_stop <= 1'b1;    // NACK, close and retry
                        frame_ok   <= 1'b0;
                        state      <= cam_pkg::end_frame;
                    end
                end
                cam_pkg::send_data: begin
                    if (byte_done) begin
                        frame_stop <= 1'b1;
                        frame_ok   <= ack_ok;
                        state      <= cam_pkg::end_frame;
                    end
                end
                cam_pkg::end_frame: begin
                    if (stop_done) begin
                        delay_start <= 1'b1;
                        long_delay  <= frame_ok && last_entry;  // Final settle
                        if (frame_ok)
                            idx <= idx + 1'b1;                  // Retry same idx on NACK
                        state <= cam_pkg::gap_wait;
                    end
                end
                cam_pkg::gap_wait: begin
                    if (delay_expired && idx == cam_pkg::entry_idx_t'(cam_pkg::NUM_ENTRIES)) begin
                        state       <= cam_pkg::config_done;
                        status      <= cam_pkg::STATUS_DONE;
                        config_done <= 1'b1;
                    end else if (delay_expired) begin
                        state       <= cam_pkg::send_id;
                        frame_start <= 1'b1;
                        frame_ok    <= 1'b1;
                        status      <= cam_pkg::STATUS_ID;
                    end
                end
                default: state <= cam_pkg::config_done;  // Terminal, outputs held
            endcase
        end
    end

endmodule

// File: source/cam_pkg.sv
package cam_pkg;

    typedef logic [7:0]  byte_t;       // One SCCB byte
    typedef logic [15:0] reg_entry_t;  // {register address, register data}
    typedef logic [6:0]  entry_idx_t;  // Table position
    typedef logic [3:0]  status_t;     // LED pattern

    typedef enum logic [2:0] {
        power_up_wait,  // Camera settling after reset
        send_id,        // START plus write ID
        send_addr,      // Register address byte
        send_data,      // Register data byte
        end_frame,      // STOP in flight
        gap_wait,       // Short gap, or final long delay
        config_done     // All entries written
    } init_state_t;

    localparam byte_t SCCB_WRITE_ID = 8'h42;  // OV7670 write address
    localparam int    NUM_ENTRIES   = 78;

    localparam int SCL_QUARTER     = 125;  // 50 MHz / (4 * 125) = 100 kHz
    localparam int SHORT_DELAY_BIT = 16;   // About 1.3 ms at 50 MHz
    localparam int LONG_DELAY_BIT  = 26;   // About 1.3 s at 50 MHz

    localparam status_t STATUS_RESET = 4'b0001;
    localparam status_t STATUS_ID    = 4'b1000;
    localparam status_t STATUS_ADDR  = 4'b0100;
    localparam status_t STATUS_DATA  = 4'b0010;
    localparam status_t STATUS_DONE  = 4'b1111;

    // Written in order, one frame per entry
    localparam reg_entry_t INIT_TABLE [0:NUM_ENTRIES-1] = '{
        16'h12_80, 16'h12_04,  // COM7 soft reset, then RGB
        16'h15_00, 16'h40_d0,  // COM10, COM15 RGB565
        16'h12_04, 16'h11_80,  // COM7 again, CLKRC
        16'h0C_00, 16'h3E_00,  // COM3, COM14 no scaling
        16'h04_00, 16'h40_d0,  // COM1 no CCIR656, COM15 full range
        16'h3a_04, 16'h14_18,  // TSLB output order, COM9 AGC ceiling
        16'h4F_B3, 16'h50_B3,  // Colour matrix MTX1..MTX2
        16'h51_00, 16'h52_3d,  // MTX3..MTX4
        16'h53_A7, 16'h54_E4,  // MTX5..MTX6
        16'h58_9E, 16'h3D_C0,  // MTXS, COM13 gamma on
        16'h17_14, 16'h18_02,  // HSTART, HSTOP
        16'h32_80, 16'h19_03,  // HREF, VSTART
        16'h1A_7B, 16'h03_0A,  // VSTOP, VREF
        16'h0F_41, 16'h1E_00,  // COM6, MVFP no mirror
        16'h33_0B, 16'h3C_78,  // CHLF, COM12
        16'h69_00, 16'h74_00,  // GFIX, REG74 digital gain
        16'hB0_84, 16'hB1_0c,  // Reserved colour fix, ABLC1
        16'hB2_0e, 16'hB3_80,  // Reserved, THL_ST
        16'h70_3a, 16'h71_35,  // Scaling registers
        16'h72_22, 16'h73_f0,
        16'ha2_02,             // Pixel clock delay
        16'h7a_20, 16'h7b_10,  // Gamma slope, then curve points
        16'h7c_1e, 16'h7d_35,
        16'h7e_5a, 16'h7f_69,
        16'h80_76, 16'h81_80,
        16'h82_88, 16'h83_8f,
        16'h84_96, 16'h85_a3,
        16'h86_af, 16'h87_c4,
        16'h88_d7, 16'h89_e8,
        16'h13_e0, 16'h00_00,  // COM8 AGC/AEC off, GAIN zero
        16'h10_00, 16'h0d_40,  // AECH zero, COM4
        16'h14_18, 16'ha5_05,  // COM9, BD50MAX
        16'hab_07, 16'h24_95,  // BD60MAX, AGC upper limit
        16'h25_33, 16'h26_e3,  // AGC lower limit, fast mode region
        16'h9f_78, 16'ha0_68,  // HAECC1, HAECC2
        16'ha1_03, 16'ha6_d8,  // Reserved, HAECC3
        16'ha7_d8, 16'ha8_f0,  // HAECC4, HAECC5
        16'ha9_90, 16'haa_94,  // HAECC6, HAECC7
        16'h13_e5, 16'h1E_23,  // COM8 AGC/AEC on, mirror image
        16'h69_06              // RGB gain
    };

endpackage

// File: source/sccb_byte_writer.sv
module sccb_byte_writer #(
    parameter int scl_quarter = cam_pkg::SCL_QUARTER  // Clocks per quarter SCL period
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           frame_start,  // START then tx_byte
    input  logic           byte_load,    // Next byte, SCL held low
    input  logic           frame_stop,   // STOP condition
    input  cam_pkg::byte_t tx_byte,
    output logic           scl,
    inout  wire            sda,          // Open drain
    output logic           byte_done,    // End of ninth clock
    output logic           ack_ok,       // SDA low on ninth bit
    output logic           stop_done
);
    localparam int QW = $clog2(scl_quarter + 1);

    typedef enum logic [2:0] {
        bus_free,    // SCL and SDA released
        bus_hold,    // SCL low between bytes
        send_start,
        send_bits,   // Eight data bits plus ACK slot
        send_stop
    } wr_mode_t;

    wr_mode_t       mode;
    logic [QW-1:0]  qcnt;         // Clocks within a quarter
    logic [1:0]     phase;        // Quarter within a bit
    logic [3:0]     bit_cnt;      // 0..7 data, 8 is ACK
    cam_pkg::byte_t shreg;        // MSB goes out first
    logic           sda_rel;      // 1 releases SDA
    logic           scl_next;
    logic           sda_next;
    logic           active;
    logic           quarter_end;
    logic           bit_end;

    assign active      = mode inside {send_start, send_bits, send_stop};
    assign quarter_end = active && (qcnt == QW'(scl_quarter - 1));
    assign bit_end     = quarter_end && (phase == 2'd3);

    assign sda = sda_rel ? 1'bz : 1'b0;  // Pull-up supplies the high level

    // Pin levels per quarter: low, high, high, low
    always_comb begin
        case (mode)
            bus_hold: begin
                scl_next = 1'b0;
                sda_next = 1'b1;
            end
            send_start: begin
                scl_next = phase inside {2'd1, 2'd2};
                sda_next = ~phase[1];  // Falls while SCL high
            end
            send_bits: begin
                scl_next = phase inside {2'd1, 2'd2};
                sda_next = (bit_cnt == 4'd8) ? 1'b1 : shreg[7];  // Released for ACK
            end
            send_stop: begin
                scl_next = (phase != 2'd0);
                sda_next = phase[1];   // Rises while SCL high
            end
            default: begin
                scl_next = 1'b1;
                sda_next = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode      <= bus_free;
            qcnt      <= '0;
            phase     <= 2'd0;
            bit_cnt   <= 4'd0;
            scl       <= 1'b1;
            sda_rel   <= 1'b1;
            byte_done <= 1'b0;
            ack_ok    <= 1'b0;
            stop_done <= 1'b0;
        end else begin
            scl       <= scl_next;
            sda_rel   <= sda_next;
            byte_done <= 1'b0;
            stop_done <= 1'b0;
            if (!active) begin
                qcnt  <= '0;
                phase <= 2'd0;
                if (frame_start) begin
                    mode    <= send_start;
                    bit_cnt <= 4'd0;
                end else if (byte_load) begin
                    mode    <= send_bits;
                    bit_cnt <= 4'd0;
                end else if (frame_stop) begin
                    mode <= send_stop;
                end
            end else begin
                qcnt <= quarter_end ? '0 : qcnt + 1'b1;
                if (quarter_end)
                    phase <= phase + 2'd1;
                if (mode == send_bits && bit_cnt == 4'd8 && phase == 2'd1 && quarter_end)
                    ack_ok <= (sda == 1'b0);  // Middle of SCL high
                if (bit_end) begin
                    case (mode)
                        send_start: mode <= send_bits;
                        send_bits: begin
                            if (bit_cnt == 4'd8) begin
                                mode      <= bus_hold;
                                byte_done <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                        default: begin
                            mode      <= bus_free;  // Bus idle high
                            stop_done <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && (frame_start || byte_load))
            shreg <= tx_byte;
        else if (bit_end && mode == send_bits)
            shreg <= {shreg[6:0], 1'b0};  // Next bit to MSB
    end

endmodule

// File: testbench/tb_cam_config.sv
module tb_cam_config;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int SHORT_BIT    = 5;
    localparam int LONG_BIT     = 8;
    localparam int SHORT_CYCLES = 1 << SHORT_BIT;  // Inter-frame gap
    localparam int LONG_CYCLES  = 1 << LONG_BIT;   // Power-up and final settle
    localparam int WAIT_LIMIT   = 4000;            // Cycles per wait
    localparam int MAX_FRAMES   = cam_pkg::NUM_ENTRIES * 4;

    logic             clk;
    logic             rst_n;
    logic             scl;
    wire              sda;
    logic             cmos_pwdn;
    logic             cmos_rst_n;
    cam_pkg::status_t status;
    logic             config_done;

    int               start_count;
    int               frame_count;
    logic [63:0]      start_time;
    logic [63:0]      stop_time;
    cam_pkg::byte_t   frame_id;
    cam_pkg::byte_t   frame_addr;
    cam_pkg::byte_t   frame_data;
    int               frame_bytes;
    int               nack_at;
    logic             frame_acked;

    int               acked_entries;  // Model position in INIT_TABLE
    int               retries;
    int               errors;
    logic [63:0]      reset_time;

    pullup (sda);

    cam_config_top #(
        .scl_quarter     (2),
        .short_delay_bit (SHORT_BIT),
        .long_delay_bit  (LONG_BIT)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .scl         (scl),
        .sda         (sda),
        .cmos_pwdn   (cmos_pwdn),
        .cmos_rst_n  (cmos_rst_n),
        .status      (status),
        .config_done (config_done)
    );

    tb_sccb_slave camera (
        .scl         (scl),
        .sda         (sda),
        .start_count (start_count),
        .frame_count (frame_count),
        .start_time  (start_time),
        .stop_time   (stop_time),
        .frame_id    (frame_id),
        .frame_addr  (frame_addr),
        .frame_data  (frame_data),
        .frame_bytes (frame_bytes),
        .nack_at     (nack_at),
        .frame_acked (frame_acked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, actual,
                     expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Stopped on failure");
    endtask

    // LED pattern of the byte a frame ended on
    function automatic cam_pkg::status_t phase_status(input int bytes_sent);
        case (bytes_sent)
            1:       return cam_pkg::STATUS_ID;
            2:       return cam_pkg::STATUS_ADDR;
            default: return cam_pkg::STATUS_DATA;
        endcase
    endfunction

    task automatic wait_for_start(input int seen);
        int cycles;
        cycles = 0;
        while (start_count == seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (start_count == seen)
            report_failure("Timeout: the controller never began the next frame");
    endtask

    task automatic wait_for_frame(input int seen);
        int cycles;
        cycles = 0;
        while (frame_count == seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (frame_count == seen)
            report_failure("Timeout: a started frame was never closed with a STOP");
    endtask

    task automatic wait_for_config_done();
        int cycles;
        cycles = 0;
        while (config_done !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (config_done !== 1'b1)
            report_failure("Timeout: config_done never rose after the last entry");
    endtask

    // Done must not show before the whole table is acked
    always @(negedge clk) begin
        if (rst_n && acked_entries < cam_pkg::NUM_ENTRIES) begin
            compare_value("config_done", config_done, 1'b0);
            compare_value("status_is_done", status == cam_pkg::STATUS_DONE, 1'b0);
        end
    end

    initial begin
        int                  seen_starts;
        int                  seen_frames;
        cam_pkg::reg_entry_t expected;
        rst_n         = 1'b0;
        acked_entries = 0;
        retries       = 0;
        errors        = 0;
        seen_starts   = 0;
        seen_frames   = 0;
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        reset_time = $time;
        @(negedge clk);  // Still reset values here
        compare_value("status", status, cam_pkg::STATUS_RESET);
        compare_value("config_done", config_done, 1'b0);
        compare_value("scl", scl, 1'b1);
        compare_value("sda", sda, 1'b1);
        compare_value("cmos_pwdn", cmos_pwdn, 1'b0);
        compare_value("cmos_rst_n", cmos_rst_n, 1'b1);

        while (acked_entries < cam_pkg::NUM_ENTRIES) begin
            if (seen_frames >= MAX_FRAMES)
                report_failure("Too many frames without finishing the register table");
            wait_for_start(seen_starts);
            seen_starts = start_count;
            if (seen_frames == 0)
                compare_value("power_up_delay_ok",
                              (start_time - reset_time) >= LONG_CYCLES * CLK_PERIOD, 1'b1);
            else
                compare_value("frame_gap_ok",
                              (start_time - stop_time) >= SHORT_CYCLES * CLK_PERIOD, 1'b1);
            wait_for_frame(seen_frames);
            seen_frames = frame_count;
            compare_value("start_count", start_count, seen_starts);  // One START per frame
            compare_value("frame_id", frame_id, cam_pkg::SCCB_WRITE_ID);
            compare_value("status", status, phase_status(frame_bytes));  // Held through STOP
            expected = cam_pkg::INIT_TABLE[acked_entries];
            if (frame_acked) begin
                compare_value("frame_bytes", frame_bytes, 3);
                compare_value("frame_addr", frame_addr, expected[15:8]);
                compare_value("frame_data", frame_data, expected[7:0]);
                acked_entries = acked_entries + 1;
            end else begin
                compare_value("frame_bytes", frame_bytes, nack_at);  // STOP right after NACK
                if (frame_bytes >= 2)
                    compare_value("frame_addr", frame_addr, expected[15:8]);
                if (frame_bytes == 3)
                    compare_value("frame_data", frame_data, expected[7:0]);
                retries = retries + 1;  // Same entry expected next
            end
        end

        compare_value("retried_frames_seen", retries > 0, 1'b1);
        wait_for_config_done();
        compare_value("final_delay_ok", ($time - stop_time) >= LONG_CYCLES * CLK_PERIOD, 1'b1);
        compare_value("status", status, cam_pkg::STATUS_DONE);
        repeat (LONG_CYCLES) begin  // Terminal state with idle bus
            @(negedge clk);
            compare_value("config_done", config_done, 1'b1);
            compare_value("status", status, cam_pkg::STATUS_DONE);
            compare_value("scl", scl, 1'b1);
            compare_value("sda", sda, 1'b1);
        end
        compare_value("start_count", start_count, seen_starts);
        compare_value("frame_count", frame_count, seen_frames);

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: testbench/tb_sccb_slave.sv
module tb_sccb_slave (
    input  logic           scl,
    inout  wire            sda,
    output int             start_count,  // STARTs seen so far
    output int             frame_count,  // STOPs closing a frame
    output logic [63:0]    start_time,   // Time of latest START
    output logic [63:0]    stop_time,    // Time of latest STOP
    output cam_pkg::byte_t frame_id,
    output cam_pkg::byte_t frame_addr,
    output cam_pkg::byte_t frame_data,
    output int             frame_bytes,  // Bytes clocked in this frame
    output int             nack_at,      // First refused byte, 0 if none
    output logic           frame_acked
);
    timeunit 1ns;
    timeprecision 1ps;

    integer         seed;
    logic           pull_low;    // Drives the ACK
    logic           in_frame;
    logic           ack_slot;    // Ninth clock in progress
    int             bit_cnt;
    int             byte_cnt;
    int             first_nack;
    cam_pkg::byte_t shift;
    cam_pkg::byte_t rx [0:2];

    assign sda = pull_low ? 1'b0 : 1'bz;  // Open drain like the real sensor

    initial begin
        seed        = 64;
        pull_low    = 1'b0;
        in_frame    = 1'b0;
        ack_slot    = 1'b0;
        bit_cnt     = 0;
        byte_cnt    = 0;
        first_nack  = 0;
        start_count = 0;
        frame_count = 0;
        start_time  = '0;
        stop_time   = '0;
    end

    // START: SDA falls while SCL high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            in_frame    = 1'b1;
            ack_slot    = 1'b0;
            bit_cnt     = 0;
            byte_cnt    = 0;
            first_nack  = 0;
            rx[0]       = '0;
            rx[1]       = '0;
            rx[2]       = '0;
            start_time  = $time;
            start_count = start_count + 1;  // Last, so fields are ready
        end
    end

    // STOP: SDA rises while SCL high
    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame) begin
            in_frame    = 1'b0;
            frame_id    = rx[0];
            frame_addr  = rx[1];
            frame_data  = rx[2];
            frame_bytes = byte_cnt;
            nack_at     = first_nack;
            frame_acked = (first_nack == 0);
            stop_time   = $time;
            frame_count = frame_count + 1;
        end
    end

    always @(posedge scl) begin
        if (in_frame && bit_cnt < 8) begin
            shift   = {shift[6:0], sda};  // MSB first
            bit_cnt = bit_cnt + 1;
        end
    end

    // ACK driven from the eighth falling edge to the ninth
    always @(negedge scl) begin
        if (in_frame && ack_slot) begin
            pull_low = 1'b0;
            ack_slot = 1'b0;
            if (byte_cnt < 3)
                rx[byte_cnt] = shift;
            byte_cnt = byte_cnt + 1;
            bit_cnt  = 0;
        end else if (in_frame && bit_cnt == 8) begin
            ack_slot = 1'b1;
            if (($random(seed) & 7) == 0) begin  // About one byte in eight refused
                if (first_nack == 0)
                    first_nack = byte_cnt + 1;
            end else begin
                pull_low = 1'b1;
            end
        end
    end

endmodule
